//--- divUnit.f
logic/divPkg.sv
logic/divIterStage.sv
logic/divSeqCtrl.sv
logic/divDatapath.sv
logic/divUnit.sv
sim/divUnit_properties.sv
sim/divUnitTb.sv

//--- logic/divDatapath.sv
// Divider datapath registers
`timescale 1ns/1ps

module divDatapath (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            load,
  input  logic            iterate,
  input  logic            hold,
  input  divPkg::divReqT  req,
  output divPkg::divRespT resp
);

  import divPkg::*;

  logic [MantWidth-1:0]          divisor;
  logic [RemWidth-1:0]           remainder;  // holds the already shifted remainder
  logic [MantWidth-1:0]          quotient;
  logic                          lastQBit;   // picks add or sub for next cell
  logic signed [ExpResWidth-1:0] expRes;

  logic [RemWidth-1:0]           stageRem;
  logic [CellsPerCycle-1:0]      stageQBits;
  logic signed [ExpResWidth-1:0] expNext;
  logic                          loadEn;
  logic                          iterEn;

  assign loadEn = load & ~hold;
  assign iterEn = iterate & ~hold;

  //////////////////////////////
  // iteration stage
  //////////////////////////////

  divIterStage u_divIterStage (
    .rem      (remainder),
    .divisor  (divisor),
    .prevQBit (lastQBit),
    .nextRem  (stageRem),
    .qBits    (stageQBits)
  );

  //////////////////////////////
  // mantissa registers
  //////////////////////////////

  // The first cell sees the raw numerator and subtracts, so the first
  // quotient bit has weight 2^23 and tells whether num >= den.
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      divisor   <= '0;
      remainder <= '0;
      quotient  <= '0;
      lastQBit  <= 1'b0;
    end
    else if (loadEn)
    begin
      divisor   <= req.denMant;
      remainder <= {1'b0, req.numMant};
      quotient  <= '0;
      lastQBit  <= 1'b1;  // start with a subtract
    end
    else if (iterEn)
    begin
      remainder <= stageRem;
      quotient  <= {quotient[MantWidth-CellsPerCycle-1:0], stageQBits};
      lastQBit  <= stageQBits[0];
    end
  end

  //////////////////////////////
  // exponent
  //////////////////////////////

  // numExp - denExp + bias, widened before the subtract
  assign expNext = signed'(ExpResWidth'(req.numExp))
                 - signed'(ExpResWidth'(req.denExp))
                 + signed'(ExpResWidth'(ExpBias));

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      expRes <= '0;
    end
    else if (loadEn)
    begin
      expRes <= expNext;
    end
  end

  //////////////////////////////
  // result
  //////////////////////////////

  // each bit is the sign test of a remainder kept in (-den, den), so the
  // shifted bits already form floor(num * 2^23 / den)
  assign resp.quotMant   = quotient;
  assign resp.expPrenorm = expRes;

endmodule

//--- logic/divIterStage.sv
// Non-restoring division stage
`timescale 1ns/1ps

module divIterStage (
  input  logic [divPkg::RemWidth-1:0]      rem,
  input  logic [divPkg::MantWidth-1:0]     divisor,
  input  logic                             prevQBit,
  output logic [divPkg::RemWidth-1:0]      nextRem,
  output logic [divPkg::CellsPerCycle-1:0] qBits
);

  import divPkg::*;

  logic [CellsPerCycle:0][RemWidth-1:0] chainRem;  // remainder between cells
  logic [CellsPerCycle:0]               chainQ;    // quotient bit between cells
  logic [RemWidth-1:0]                  divExt;

  assign divExt      = {1'b0, divisor};  // sign extension
  assign chainRem[0] = rem;
  assign chainQ[0]   = prevQBit;

  // Each cell subtracts the divisor when the previous quotient bit is 1 and
  // adds it back otherwise. The result is kept modulo 2^RemWidth: the true
  // value always lies in (-divisor, divisor), so the sign bit stays valid
  // even though the doubled remainder overflows the register.
  for (genvar i = 0; i < CellsPerCycle; i++)
  begin : gCell
    logic [RemWidth-1:0] sum;

    always_comb
    begin
      if (chainQ[i])
      begin
        sum = chainRem[i] - divExt;
      end
      else
      begin
        sum = chainRem[i] + divExt;
      end
    end

    assign chainQ[i+1]   = ~sum[RemWidth-1];  // non-negative -> 1
    assign chainRem[i+1] = {sum[RemWidth-2:0], 1'b0};  // shift for next cell

    // msb first
    assign qBits[CellsPerCycle-1-i] = chainQ[i+1];
  end

  assign nextRem = chainRem[CellsPerCycle];

endmodule

//--- logic/divPkg.sv
// Mantissa divider shared definitions

package divPkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////

  localparam int unsigned MantWidth     = 24;  // hidden bit included
  localparam int unsigned RemWidth      = MantWidth + 1;  // partial remainder, with sign
  localparam int unsigned ExpWidth      = 8;
  localparam int unsigned ExpResWidth   = 10;  // room for overflow and sign
  localparam int unsigned ExpBias       = 127;
  localparam int unsigned CellsPerCycle = 4;   // cells chained in one clock
  localparam int unsigned NumCycles     = MantWidth / CellsPerCycle;
  localparam int unsigned CntWidth      = 3;

  //////////////////////////////
  // request / response
  //////////////////////////////

  // one division request, 64 bits
  typedef struct packed {
    logic [MantWidth-1:0] numMant;
    logic [MantWidth-1:0] denMant;
    logic [ExpWidth-1:0]  numExp;
    logic [ExpWidth-1:0]  denExp;
  } divReqT;

  // pre-normalization result, 34 bits
  typedef struct packed {
    logic [MantWidth-1:0]          quotMant;
    logic signed [ExpResWidth-1:0] expPrenorm;
  } divRespT;

endpackage

//--- logic/divSeqCtrl.sv
// Divider sequence control
`timescale 1ns/1ps

module divSeqCtrl (
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic inValid,
  output logic inReady,
  output logic outValid,
  input  logic outReady,
  output logic load,
  output logic iterate,
  output logic hold
);

  import divPkg::*;

  logic                busy;      // job accepted, result not yet taken
  logic                resValid;  // iterations done
  logic [CntWidth-1:0] iterCnt;
  logic                lastIter;
  logic                accept;
  logic                take;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  assign inReady  = ~busy;
  assign outValid = resValid;
  assign accept   = inValid & inReady;
  assign take     = resValid & outReady;

  //////////////////////////////
  // datapath strobes
  //////////////////////////////

  assign load     = accept;
  assign iterate  = busy & ~resValid;
  assign hold     = resValid;  // result frozen until taken
  assign lastIter = iterate && (iterCnt == CntWidth'(NumCycles - 1));

  // iteration counter
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      iterCnt <= '0;
    end
    else if (accept || lastIter)
    begin
      iterCnt <= '0;
    end
    else if (iterate)
    begin
      iterCnt <= iterCnt + 1'b1;
    end
  end

  // busy spans accept up to the output handshake
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      busy <= 1'b0;
    end
    else if (accept)
    begin
      busy <= 1'b1;
    end
    else if (take)
    begin
      busy <= 1'b0;
    end
  end

  // result valid after the last iteration edge
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      resValid <= 1'b0;
    end
    else if (lastIter)
    begin
      resValid <= 1'b1;
    end
    else if (take)
    begin
      resValid <= 1'b0;
    end
  end

endmodule

//--- logic/divUnit.sv
// Mantissa divider top level
`timescale 1ns/1ps

module divUnit (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            inValid,
  output logic            inReady,
  input  divPkg::divReqT  inReq,
  output logic            outValid,
  input  logic            outReady,
  output divPkg::divRespT outResp
);

  //////////////////////////////
  // control to datapath
  //////////////////////////////

  logic load;     // accept cycle
  logic iterate;  // one of the iteration cycles
  logic hold;     // result waiting for the sink

  divSeqCtrl u_divSeqCtrl (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .inValid  (inValid),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .load     (load),
    .iterate  (iterate),
    .hold     (hold)
  );

  // remainder, quotient and exponent registers with the cell chain
  divDatapath u_divDatapath (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .load    (load),
    .iterate (iterate),
    .hold    (hold),
    .req     (inReq),
    .resp    (outResp)
  );

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the divider testbench with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module divUnitTb -f divUnit.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/VdivUnitTb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- sim/divUnitTb.sv
// Mantissa divider testbench
`timescale 1ns/1ps

module divUnitTb;

  import divPkg::*;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 8;
  localparam int NumTests    = 5;
  localparam int MaxTrans    = 30;  // largest test, the random pairs
  localparam int MaxStall    = 10;
  localparam int Margin      = 8;
  localparam int TimeoutNs   = (ResetCycles + NumTests * MaxTrans
                               * (int'(NumCycles) + MaxStall + Margin)) * ClkPeriod;

  logic    Clk_CI;
  logic    Rst_RBI;
  logic    inValid;
  logic    inReady;
  divReqT  inReq;
  logic    outValid;
  logic    outReady;
  divRespT outResp;
  integer  seed;

  divUnit u_divUnit (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .inValid  (inValid),
    .inReady  (inReady),
    .inReq    (inReq),
    .outValid (outValid),
    .outReady (outReady),
    .outResp  (outResp)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever
    begin
      #(ClkPeriod / 2) Clk_CI = ~Clk_CI;
    end
  end

  // watchdog
  initial
  begin
    #(TimeoutNs);
    $display("the run timed out after %0d ns before all tests finished", TimeoutNs);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // error reporting
  //////////////////////////////

  task automatic valueError(input string testName, input string what,
                            input logic [63:0] expected, input logic [63:0] actual);
    $display("FAILED %s %s expected %0h actual %0h", testName, what, expected, actual);
    $display("Something failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic protocolError(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "protocol error");
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // floor(num * 2^23 / den)
  function automatic logic [MantWidth-1:0] floorQuotient(input logic [MantWidth-1:0] num,
                                                         input logic [MantWidth-1:0] den);
    logic [2*MantWidth-1:0] wide;
    logic [2*MantWidth-1:0] q;
    wide = {1'b0, num, 23'd0};
    q    = wide / {{MantWidth{1'b0}}, den};
    return q[MantWidth-1:0];
  endfunction

  // numExp - denExp + bias, two's complement
  function automatic logic signed [ExpResWidth-1:0] prenormExponent(
    input logic [ExpWidth-1:0] numExp, input logic [ExpWidth-1:0] denExp);
    int e;
    e = int'(numExp) - int'(denExp) + int'(ExpBias);
    return ExpResWidth'(e);
  endfunction

  task automatic drawOperands(output divReqT req);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    req.numMant = {1'b1, r0[22:0]};  // hidden bit forced
    req.denMant = {1'b1, r1[22:0]};
    req.numExp  = r2[7:0];
    req.denExp  = r2[15:8];
  endtask

  //////////////////////////////
  // one transaction
  //////////////////////////////

  task automatic divideOnce(input string testName, input divReqT req,
                            input int stall, input bit readyHigh);
    divRespT expResp;
    divRespT held;
    int      waited;
    int      i;
    expResp.quotMant   = floorQuotient(req.numMant, req.denMant);
    expResp.expPrenorm = prenormExponent(req.numExp, req.denExp);
    assert (inReady == 1'b1)
      else valueError(testName, "inReady before request", 64'd1, 64'(inReady));
    inValid  = 1'b1;
    inReq    = req;
    outReady = readyHigh;
    @(posedge Clk_CI);  // accept edge
    @(negedge Clk_CI);
    inValid = 1'b0;
    inReq   = '0;
    waited  = 0;
    while (!outValid && waited < int'(NumCycles) + Margin)
    begin
      assert (inReady == 1'b0)
        else valueError(testName, "inReady while busy", 64'd0, 64'(inReady));
      @(posedge Clk_CI);
      @(negedge Clk_CI);
      waited++;
    end
    assert (outValid)
      else protocolError($sformatf("%s: no result within %0d cycles of the accept",
                                   testName, waited));
    assert (waited == int'(NumCycles))
      else valueError(testName, "latency", 64'(NumCycles), 64'(waited));
    assert (outResp.quotMant == expResp.quotMant)
      else valueError(testName, "quotMant", 64'(expResp.quotMant), 64'(outResp.quotMant));
    assert (outResp.expPrenorm == expResp.expPrenorm)
      else valueError(testName, "expPrenorm", 64'(expResp.expPrenorm),
                      64'(outResp.expPrenorm));
    held = outResp;
    // sink stalls, result must sit still
    for (i = 0; i < stall; i++)
    begin
      @(posedge Clk_CI);
      @(negedge Clk_CI);
      assert (outValid && !inReady)
        else protocolError($sformatf("%s: result dropped or input reopened during a stall",
                                     testName));
      assert (outResp == held)
        else valueError(testName, "held outResp", 64'(held), 64'(outResp));
    end
    outReady = 1'b1;
    @(posedge Clk_CI);  // take edge
    @(negedge Clk_CI);
    outReady = readyHigh;
    assert (!outValid && inReady)
      else protocolError($sformatf("%s: divider not idle after the result was taken",
                                   testName));
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic checkResetState();
    int i;
    for (i = 0; i < ResetCycles; i++)
    begin
      @(negedge Clk_CI);
      assert (inReady == 1'b1)
        else valueError("reset", "inReady in reset", 64'd1, 64'(inReady));
      assert (outValid == 1'b0)
        else valueError("reset", "outValid in reset", 64'd0, 64'(outValid));
    end
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    assert (inReady == 1'b1)
      else valueError("reset", "inReady after reset", 64'd1, 64'(inReady));
    assert (outValid == 1'b0)
      else valueError("reset", "outValid after reset", 64'd0, 64'(outValid));
  endtask

  task automatic runDirectedCases();
    divReqT req;
    // equal mantissas, quotient 2^23
    req = '{numMant: 24'hC00000, denMant: 24'hC00000, numExp: 8'd127, denExp: 8'd127};
    divideOnce("directed equal", req, 0, 1'b1);
    req = '{numMant: 24'hFFFFFF, denMant: 24'h800000, numExp: 8'd200, denExp: 8'd100};
    divideOnce("directed max over min", req, 0, 1'b1);
    // exponent goes negative here
    req = '{numMant: 24'h800000, denMant: 24'hFFFFFF, numExp: 8'd1, denExp: 8'd254};
    divideOnce("directed min over max", req, 0, 1'b1);
    req = '{numMant: 24'hA5A5A5, denMant: 24'hD00001, numExp: 8'd254, denExp: 8'd1};
    divideOnce("directed exponent overflow", req, 0, 1'b1);
  endtask

  task automatic runRandomPairs();
    divReqT req;
    int     n;
    for (n = 0; n < MaxTrans; n++)
    begin
      drawOperands(req);
      divideOnce($sformatf("random %0d", n), req, 0, 1'b1);
    end
  endtask

  // outReady stays low until the result shows up
  task automatic measureLatency();
    divReqT req;
    int     n;
    for (n = 0; n < 5; n++)
    begin
      drawOperands(req);
      divideOnce($sformatf("latency %0d", n), req, 0, 1'b0);
    end
  endtask

  task automatic applyBackPressure();
    divReqT      req;
    logic [31:0] r;
    int          n;
    for (n = 0; n < 10; n++)
    begin
      drawOperands(req);
      r = $random(seed);
      divideOnce($sformatf("backpressure %0d", n), req, int'(r % 32'd11), 1'b0);
    end
  endtask

  initial
  begin
    Rst_RBI  = 1'b0;
    inValid  = 1'b0;
    inReq    = '0;
    outReady = 1'b0;
    seed     = 32'he582_9ec1;
    checkResetState();
    runDirectedCases();
    runRandomPairs();
    measureLatency();
    applyBackPressure();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- sim/divUnit_properties.sv
// Divider handshake assertions
`timescale 1ns/1ps

module divUnitProperties (
  input logic            Clk_CI,
  input logic            Rst_RBI,
  input logic            inValid,
  input logic            inReady,
  input logic            outValid,
  input logic            outReady,
  input divPkg::divRespT outResp
);

  import divPkg::*;

  logic accept;

  assign accept = inValid & inReady;

  // result frozen while the sink stalls
  aRespHeld: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (outValid && !outReady) |=> (outValid && $stable(outResp)))
    else $error("outValid or outResp changed while outReady was low");

  aOneSide: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(inReady && outValid))
    else $error("inReady and outValid were high together");

  ////////////////////////////////
  // fixed latency in both directions
  ////////////////////////////////

  // outValid set on the sixth edge after the accept edge is first sampled
  // high one tick later
  aNoEarly: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    $rose(outValid) |-> $past(accept, NumCycles + 1))
    else $error("outValid rose without an accept six cycles before");

  aNoLate: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    $past(accept, NumCycles + 1) |-> $rose(outValid))
    else $error("outValid did not rise six cycles after an accept");

endmodule

bind divUnit divUnitProperties u_divUnitProperties (
  .Clk_CI   (Clk_CI),
  .Rst_RBI  (Rst_RBI),
  .inValid  (inValid),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .outResp  (outResp)
);
